/* Bender.yml */
package:
  name: prefetching

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/prefetch_pkg.sv
      - hdl/pref_feedback_if.sv
      - hdl/inst_next_line.sv
      - hdl/data_stride_table.sv
      - hdl/pref_issue_fsm.sv
      - hdl/pref_stats.sv
      - hdl/prefetching.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/tb_prefetching.sv

/* compile.f */
+incdir+hdl
hdl/prefetch_pkg.sv
hdl/pref_feedback_if.sv
hdl/inst_next_line.sv
hdl/data_stride_table.sv
hdl/pref_issue_fsm.sv
hdl/pref_stats.sv
hdl/prefetching.sv
verification/tb_prefetching.sv

/* hdl/data_stride_table.sv */
/*
 * data side stride table, indexed by load pc
 * confident entries propose line+stride, L2 hits lower confidence
 */
`timescale 1ns/1ps
`include "prefetch_settings.svh"

module data_stride_table (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic [`PREF_ADDR_WIDTH-1:0]  pc,
    input  logic [`PREF_ADDR_WIDTH-1:0]  addr,
    input  logic                         access_valid,
    input  logic                         anneal_valid,
    input  logic [`PREF_ADDR_WIDTH-1:0]  anneal_pc,
    pref_feedback_if.predictor           fb,
    output logic                         cand_valid,
    output logic [`PREF_LINE_WIDTH-1:0]  cand_line,
    output logic [`PREF_INDEX_WIDTH-1:0] cand_index
);

    localparam int ENTRIES   = 1 << `PREF_INDEX_WIDTH;
    localparam int TAG_LSB   = `PREF_INDEX_WIDTH + 2;

    prefetch_pkg::stride_entry_t table_q [ENTRIES];
    prefetch_pkg::stride_entry_t entry;
    prefetch_pkg::stride_entry_t entry_new;

    logic [`PREF_INDEX_WIDTH-1:0]         acc_idx;
    logic [`PREF_INDEX_WIDTH-1:0]         ann_idx;
    logic [`PREF_ADDR_WIDTH-TAG_LSB-1:0]  acc_tag;
    logic [`PREF_LINE_WIDTH-1:0]          acc_line;
    logic [`PREF_LINE_WIDTH-1:0]          new_stride;
    logic                                 tag_hit;
    logic                                 same_stride;
    logic                                 issue;
    logic                                 fb_apply;
    logic                                 ann_apply;

    assign acc_idx  = pc[TAG_LSB-1:2];
    assign acc_tag  = pc[`PREF_ADDR_WIDTH-1:TAG_LSB];
    assign ann_idx  = anneal_pc[TAG_LSB-1:2];
    assign acc_line = addr[`PREF_ADDR_WIDTH-1:`PREF_LINE_OFFSET];

    assign entry       = table_q[acc_idx];
    assign tag_hit     = entry.valid && entry.tag == acc_tag;
    assign new_stride  = acc_line - entry.last_line;
    assign same_stride = new_stride == entry.stride && new_stride != '0;

    // updated entry for the current access
    always_comb begin
        entry_new.valid     = 1'b1;
        entry_new.tag       = acc_tag;
        entry_new.last_line = acc_line;
        if (!tag_hit) begin
            entry_new.stride = '0;
            entry_new.conf   = '0;
        end else if (same_stride) begin
            entry_new.stride = entry.stride;
            if (entry.conf == 2'(`PREF_CONF_MAX)) begin
                entry_new.conf = entry.conf;
            end else begin
                entry_new.conf = entry.conf + 1'b1;
            end
        end else begin
            entry_new.stride = new_stride;
            entry_new.conf   = '0;
        end
    end

    assign issue = tag_hit && entry_new.conf >= 2'(`PREF_CONF_THRESHOLD);

    // a useless prefetch (L2 already had the line) costs confidence
    assign fb_apply = fb.update && fb.hit && fb.kind == prefetch_pkg::KIND_DATA
                      && !(access_valid && acc_idx == fb.index);
    assign ann_apply = anneal_valid && !(access_valid && acc_idx == ann_idx);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < ENTRIES; i++) begin
                table_q[i].valid <= 1'b0;
            end
        end else begin
            if (fb_apply && table_q[fb.index].conf != 2'd0) begin
                table_q[fb.index].conf <= table_q[fb.index].conf - 1'b1;
            end
            if (ann_apply) begin
                table_q[ann_idx].valid <= 1'b0;
            end
            if (access_valid) begin
                table_q[acc_idx] <= entry_new;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            cand_valid <= 1'b0;
        end else begin
            cand_valid <= access_valid && issue;
        end
    end

    // stride is unchanged when issuing
    always_ff @(posedge clk) begin
        if (access_valid) begin
            cand_line  <= acc_line + entry_new.stride;
            cand_index <= acc_idx;
        end
    end

endmodule

/* hdl/inst_next_line.sv */
/*
 * instruction side next-line predictor
 * proposes line+1 whenever the fetch line changes
 */
`timescale 1ns/1ps
`include "prefetch_settings.svh"

module inst_next_line (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic [`PREF_ADDR_WIDTH-1:0] fetch_addr,
    input  logic                        anneal_inst,
    pref_feedback_if.predictor          fb,
    output logic                        cand_valid,
    output logic [`PREF_LINE_WIDTH-1:0] cand_line
);

    logic [`PREF_LINE_WIDTH-1:0] fetch_line;
    logic [`PREF_LINE_WIDTH-1:0] last_line;
    logic                        last_valid;

    assign fetch_line = fetch_addr[`PREF_ADDR_WIDTH-1:`PREF_LINE_OFFSET];

    // next-line prediction needs no training, fb is bound only
    always_ff @(posedge clk) begin
        if (!rstn) begin
            last_valid <= 1'b0;
            cand_valid <= 1'b0;
        end else begin
            cand_valid <= 1'b0;
            if (anneal_inst) begin
                last_valid <= 1'b0;
            end else if (!last_valid || fetch_line != last_line) begin
                last_valid <= 1'b1;
                cand_valid <= 1'b1;
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (!anneal_inst && (!last_valid || fetch_line != last_line)) begin
            last_line <= fetch_line;
            cand_line <= fetch_line + 1'b1;
        end
    end

endmodule

/* hdl/pref_feedback_if.sv */
/*
 * completion feedback from the issue FSM to the predictors
 */
`timescale 1ns/1ps
`include "prefetch_settings.svh"

interface pref_feedback_if;

    logic                           update;
    logic                           hit;
    prefetch_pkg::pref_kind_e       kind;
    logic [`PREF_LINE_WIDTH-1:0]    line;
    logic [`PREF_INDEX_WIDTH-1:0]   index;

    modport issuer (
        output update, hit, kind, line, index
    );

    modport predictor (
        input update, hit, kind, line, index
    );

endinterface

/* hdl/pref_issue_fsm.sv */
/*
 * prefetch issue FSM, data candidates ahead of instruction
 * holds one request open to the L2 until it completes
 */
`timescale 1ns/1ps
`include "prefetch_settings.svh"

module pref_issue_fsm (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            inst_cand_valid,
    input  logic [`PREF_LINE_WIDTH-1:0]     inst_cand_line,
    input  logic                            data_cand_valid,
    input  logic [`PREF_LINE_WIDTH-1:0]     data_cand_line,
    input  logic [`PREF_INDEX_WIDTH-1:0]    data_cand_index,
    input  logic                            complete,
    input  logic                            hit,
    pref_feedback_if.issuer                 fb,
    output logic                            req,
    output prefetch_pkg::pref_kind_e        req_kind,
    output logic [`PREF_ADDR_WIDTH-1:0]     req_addr,
    output logic                            issued,
    output logic                            dropped,
    output logic                            completed,
    output logic                            completed_hit
);

    prefetch_pkg::pref_state_e      state_q;
    logic [`PREF_INDEX_WIDTH-1:0]   req_index;
    logic                           idle;
    logic                           any_cand;

    assign idle     = state_q == prefetch_pkg::IDLE;
    assign any_cand = data_cand_valid || inst_cand_valid;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q  <= prefetch_pkg::IDLE;
            req_addr <= '0;
            req_kind <= prefetch_pkg::KIND_INST;
        end else begin
            case (state_q)
                prefetch_pkg::IDLE: begin
                    if (data_cand_valid) begin
                        state_q  <= prefetch_pkg::REQ;
                        req_addr <= {data_cand_line, {`PREF_LINE_OFFSET{1'b0}}};
                        req_kind <= prefetch_pkg::KIND_DATA;
                    end else if (inst_cand_valid) begin
                        state_q  <= prefetch_pkg::REQ;
                        req_addr <= {inst_cand_line, {`PREF_LINE_OFFSET{1'b0}}};
                        req_kind <= prefetch_pkg::KIND_INST;
                    end
                end
                prefetch_pkg::REQ: begin
                    if (complete) begin
                        state_q <= prefetch_pkg::IDLE;
                    end
                end
                default: state_q <= prefetch_pkg::IDLE;
            endcase
        end
    end

    // table index only matters for data requests
    always_ff @(posedge clk) begin
        if (idle && data_cand_valid) begin
            req_index <= data_cand_index;
        end
    end

    assign req = state_q == prefetch_pkg::REQ;

    assign issued        = idle && any_cand;
    // anything lost while busy or by the instruction side on a tie
    assign dropped       = (!idle && any_cand) || (idle && data_cand_valid && inst_cand_valid);
    assign completed     = req && complete;
    assign completed_hit = completed && hit;

    assign fb.update = completed;
    assign fb.hit    = hit;
    assign fb.kind   = req_kind;
    assign fb.line   = req_addr[`PREF_ADDR_WIDTH-1:`PREF_LINE_OFFSET];
    assign fb.index  = req_index;

endmodule

/* hdl/pref_stats.sv */
/*
 * prefetch statistics, saturating event counters
 */
`timescale 1ns/1ps
`include "prefetch_settings.svh"

module pref_stats (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        issued,
    input  logic                        dropped,
    input  logic                        completed,
    input  logic                        completed_hit,
    input  logic                        annealed,
    output logic [`PREF_STAT_WIDTH-1:0] stat_issued,
    output logic [`PREF_STAT_WIDTH-1:0] stat_dropped,
    output logic [`PREF_STAT_WIDTH-1:0] stat_completed,
    output logic [`PREF_STAT_WIDTH-1:0] stat_hit,
    output logic [`PREF_STAT_WIDTH-1:0] stat_anneal
);

    localparam int N_EVENTS = 5;

    logic [N_EVENTS-1:0]         events;
    logic [`PREF_STAT_WIDTH-1:0] cnt_q [N_EVENTS];

    assign events = {annealed, completed_hit, completed, dropped, issued};

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < N_EVENTS; i++) begin
                cnt_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N_EVENTS; i++) begin
                // hold at all ones
                if (events[i] && cnt_q[i] != '1) begin
                    cnt_q[i] <= cnt_q[i] + 1'b1;
                end
            end
        end
    end

    assign stat_issued    = cnt_q[0];
    assign stat_dropped   = cnt_q[1];
    assign stat_completed = cnt_q[2];
    assign stat_hit       = cnt_q[3];
    assign stat_anneal    = cnt_q[4];

endmodule

/* hdl/prefetch_pkg.sv */
/*
 * prefetch engine types
 * issue states, request kinds and the stride table entry
 */
`include "prefetch_settings.svh"

package prefetch_pkg;

    typedef enum logic {
        IDLE = 1'b0,
        REQ  = 1'b1
    } pref_state_e;

    // same encoding as the L2 request type
    typedef enum logic {
        KIND_INST = 1'b0,
        KIND_DATA = 1'b1
    } pref_kind_e;

    typedef struct packed {
        logic                                           valid;
        logic [`PREF_ADDR_WIDTH-`PREF_INDEX_WIDTH-3:0]  tag;
        logic [`PREF_LINE_WIDTH-1:0]                    last_line;
        logic [`PREF_LINE_WIDTH-1:0]                    stride;
        logic [1:0]                                     conf;
    } stride_entry_t;

endpackage

/* hdl/prefetch_settings.svh */
/*
 * prefetch engine settings
 * address split, stride table size, confidence and counter widths
 */
`ifndef PREFETCH_SETTINGS_SVH
`define PREFETCH_SETTINGS_SVH

// byte address
`define PREF_ADDR_WIDTH     32
// 2 word bits plus 3 line bits
`define PREF_LINE_OFFSET    5
`define PREF_LINE_WIDTH     (`PREF_ADDR_WIDTH - `PREF_LINE_OFFSET)

// 16 entries, indexed by pc[5:2]
`define PREF_INDEX_WIDTH    4

// 2-bit confidence
`define PREF_CONF_MAX       3
`define PREF_CONF_THRESHOLD 2

`define PREF_STAT_WIDTH     16

`endif

/* hdl/prefetching.sv */
/*
 * L2 prefetch engine top level
 * next-line and stride predictors feeding one outstanding L2 request
 */
`timescale 1ns/1ps
`include "prefetch_settings.svh"

module prefetching (
    input  logic                        clk,
    input  logic                        rstn,
    // fetch side
    input  logic [`PREF_ADDR_WIDTH-1:0] pdc_pref_addr,
    // load side
    input  logic [`PREF_ADDR_WIDTH-1:0] dcache_pref_addr,
    input  logic [`PREF_ADDR_WIDTH-1:0] dcache_pref_pc,
    input  logic                        dcache_pref_valid,
    // annealing from L2, anneal_addr has no use here
    input  logic [`PREF_ADDR_WIDTH-1:0] anneal_addr,
    input  logic [`PREF_ADDR_WIDTH-1:0] anneal_pc,
    input  logic                        anneal_unhit,
    input  logic                        anneal_type,
    // L2 request
    output logic                        req_pref_l2cache,
    output logic                        type_pref_l2cache,
    output logic [`PREF_ADDR_WIDTH-1:0] addr_pref_l2cache,
    input  logic                        complete_l2cache_pref,
    input  logic                        hit_l2cache_pref,
    // statistics
    output logic [`PREF_STAT_WIDTH-1:0] stat_issued,
    output logic [`PREF_STAT_WIDTH-1:0] stat_dropped,
    output logic [`PREF_STAT_WIDTH-1:0] stat_completed,
    output logic [`PREF_STAT_WIDTH-1:0] stat_hit,
    output logic [`PREF_STAT_WIDTH-1:0] stat_anneal
);

    logic                           inst_cand_valid;
    logic [`PREF_LINE_WIDTH-1:0]    inst_cand_line;
    logic                           data_cand_valid;
    logic [`PREF_LINE_WIDTH-1:0]    data_cand_line;
    logic [`PREF_INDEX_WIDTH-1:0]   data_cand_index;
    logic                           anneal_inst;
    logic                           anneal_data;
    logic                           issued;
    logic                           dropped;
    logic                           completed;
    logic                           completed_hit;
    prefetch_pkg::pref_kind_e       req_kind;

    // anneal_type 1 is data, 0 is instruction
    assign anneal_data = anneal_unhit && anneal_type;
    assign anneal_inst = anneal_unhit && !anneal_type;

    assign type_pref_l2cache = req_kind;

    pref_feedback_if fb_if ();

    inst_next_line inst_next_line_inst (
        .clk        (clk),
        .rstn       (rstn),
        .fetch_addr (pdc_pref_addr),
        .anneal_inst(anneal_inst),
        .fb         (fb_if.predictor),
        .cand_valid (inst_cand_valid),
        .cand_line  (inst_cand_line)
    );

    data_stride_table data_stride_table_inst (
        .clk         (clk),
        .rstn        (rstn),
        .pc          (dcache_pref_pc),
        .addr        (dcache_pref_addr),
        .access_valid(dcache_pref_valid),
        .anneal_valid(anneal_data),
        .anneal_pc   (anneal_pc),
        .fb          (fb_if.predictor),
        .cand_valid  (data_cand_valid),
        .cand_line   (data_cand_line),
        .cand_index  (data_cand_index)
    );

    pref_issue_fsm pref_issue_fsm_inst (
        .clk            (clk),
        .rstn           (rstn),
        .inst_cand_valid(inst_cand_valid),
        .inst_cand_line (inst_cand_line),
        .data_cand_valid(data_cand_valid),
        .data_cand_line (data_cand_line),
        .data_cand_index(data_cand_index),
        .complete       (complete_l2cache_pref),
        .hit            (hit_l2cache_pref),
        .fb             (fb_if.issuer),
        .req            (req_pref_l2cache),
        .req_kind       (req_kind),
        .req_addr       (addr_pref_l2cache),
        .issued         (issued),
        .dropped        (dropped),
        .completed      (completed),
        .completed_hit  (completed_hit)
    );

    pref_stats pref_stats_inst (
        .clk           (clk),
        .rstn          (rstn),
        .issued        (issued),
        .dropped       (dropped),
        .completed     (completed),
        .completed_hit (completed_hit),
        .annealed      (anneal_unhit),
        .stat_issued   (stat_issued),
        .stat_dropped  (stat_dropped),
        .stat_completed(stat_completed),
        .stat_hit      (stat_hit),
        .stat_anneal   (stat_anneal)
    );

endmodule

/* verification/tb_prefetching.sv */
/*
 * testbench for the L2 prefetch engine
 * stimulus table, cycle reference model and a random-delay L2 responder
 */
`timescale 1ns/1ps
`include "prefetch_settings.svh"

module tb_prefetching;

    localparam int CLK_PERIOD   = 40;
    localparam int N_ROWS       = 26;
    localparam int MAX_GAP      = 8;
    localparam int DRAIN_CYCLES = 40;
    // reset, two strobe cycles plus the gap per row, and the drain
    localparam int WATCHDOG_CYCLES = 2 + N_ROWS * (2 + MAX_GAP) + DRAIN_CYCLES;
    localparam int ENTRIES      = 1 << `PREF_INDEX_WIDTH;
    localparam int TAG_LSB      = `PREF_INDEX_WIDTH + 2;
    localparam logic [31:0] PC_A     = 32'h0000_1004;
    localparam logic [31:0] PC_B     = 32'h0000_2008;
    // same table index as PC_A with another tag
    localparam logic [31:0] PC_ALIAS = 32'h0000_3004;

    typedef struct packed {
        logic [31:0] fetch;
        logic [31:0] pc;
        logic [31:0] addr;
        logic        ld;
        logic [31:0] an_pc;
        logic        an;
        logic        an_type;
        logic [3:0]  gap;
    } stim_row_t;

    logic                        clk;
    logic                        rstn;
    logic [`PREF_ADDR_WIDTH-1:0] pdc_pref_addr;
    logic [`PREF_ADDR_WIDTH-1:0] dcache_pref_addr;
    logic [`PREF_ADDR_WIDTH-1:0] dcache_pref_pc;
    logic                        dcache_pref_valid;
    logic [`PREF_ADDR_WIDTH-1:0] anneal_addr;
    logic [`PREF_ADDR_WIDTH-1:0] anneal_pc;
    logic                        anneal_unhit;
    logic                        anneal_type;
    logic                        req_pref_l2cache;
    logic                        type_pref_l2cache;
    logic [`PREF_ADDR_WIDTH-1:0] addr_pref_l2cache;
    logic                        complete_l2cache_pref;
    logic                        hit_l2cache_pref;
    logic [`PREF_STAT_WIDTH-1:0] stat_issued;
    logic [`PREF_STAT_WIDTH-1:0] stat_dropped;
    logic [`PREF_STAT_WIDTH-1:0] stat_completed;
    logic [`PREF_STAT_WIDTH-1:0] stat_hit;
    logic [`PREF_STAT_WIDTH-1:0] stat_anneal;

    stim_row_t rows [N_ROWS];
    logic      checking = 1'b0;
    logic      req_seen = 1'b0;
    int        resp_wait = 0;
    int        err_count = 0;
    int        check_count = 0;

    // reference model state
    prefetch_pkg::stride_entry_t  ref_table [ENTRIES];
    logic                         nl_valid;
    logic [`PREF_LINE_WIDTH-1:0]  nl_last;
    logic                         m_inst_cv;
    logic [`PREF_LINE_WIDTH-1:0]  m_inst_line;
    logic                         m_data_cv;
    logic [`PREF_LINE_WIDTH-1:0]  m_data_line;
    logic [`PREF_INDEX_WIDTH-1:0] m_data_idx;
    logic                         m_busy;
    logic [`PREF_ADDR_WIDTH-1:0]  m_addr;
    logic                         m_kind;
    logic [`PREF_INDEX_WIDTH-1:0] m_idx;
    int n_issued = 0;
    int n_dropped = 0;
    int n_completed = 0;
    int n_hit = 0;
    int n_anneal = 0;
    int n_data_req = 0;
    int n_inst_req = 0;

    prefetching prefetching_inst (
        .clk                  (clk),
        .rstn                 (rstn),
        .pdc_pref_addr        (pdc_pref_addr),
        .dcache_pref_addr     (dcache_pref_addr),
        .dcache_pref_pc       (dcache_pref_pc),
        .dcache_pref_valid    (dcache_pref_valid),
        .anneal_addr          (anneal_addr),
        .anneal_pc            (anneal_pc),
        .anneal_unhit         (anneal_unhit),
        .anneal_type          (anneal_type),
        .req_pref_l2cache     (req_pref_l2cache),
        .type_pref_l2cache    (type_pref_l2cache),
        .addr_pref_l2cache    (addr_pref_l2cache),
        .complete_l2cache_pref(complete_l2cache_pref),
        .hit_l2cache_pref     (hit_l2cache_pref),
        .stat_issued          (stat_issued),
        .stat_dropped         (stat_dropped),
        .stat_completed       (stat_completed),
        .stat_hit             (stat_hit),
        .stat_anneal          (stat_anneal)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic fill_table();
        // fetch addr  load pc   load addr  ld  anneal pc  an  type  gap
        rows[0]  = '{32'h1000, 32'h0,    32'h0,    0, 32'h0,    0, 0, 8};
        rows[1]  = '{32'h1004, 32'h0,    32'h0,    0, 32'h0,    0, 0, 8};
        rows[2]  = '{32'h1020, 32'h0,    32'h0,    0, 32'h0,    0, 0, 8};
        rows[3]  = '{32'h1040, PC_A,     32'h8000, 1, 32'h0,    0, 0, 8};
        rows[4]  = '{32'h1040, PC_A,     32'h8040, 1, 32'h0,    0, 0, 8};
        rows[5]  = '{32'h1040, PC_A,     32'h8080, 1, 32'h0,    0, 0, 8};
        rows[6]  = '{32'h1040, PC_A,     32'h80c0, 1, 32'h0,    0, 0, 8};
        rows[7]  = '{32'h1040, PC_A,     32'h8100, 1, 32'h0,    0, 0, 8};
        rows[8]  = '{32'h1040, PC_B,     32'h9100, 1, 32'h0,    0, 0, 8};
        rows[9]  = '{32'h1040, PC_B,     32'h90e0, 1, 32'h0,    0, 0, 8};
        rows[10] = '{32'h1040, PC_B,     32'h90c0, 1, 32'h0,    0, 0, 8};
        rows[11] = '{32'h1040, PC_B,     32'h90a0, 1, 32'h0,    0, 0, 8};
        rows[12] = '{32'h1040, PC_B,     32'h9080, 1, 32'h0,    0, 0, 8};
        // both predictors fire together
        rows[13] = '{32'h1060, PC_B,     32'h9060, 1, 32'h0,    0, 0, 8};
        // back to back so the second row lands on an open request
        rows[14] = '{32'h1080, PC_A,     32'h8140, 1, 32'h0,    0, 0, 0};
        rows[15] = '{32'h10a0, PC_A,     32'h8180, 1, 32'h0,    0, 0, 0};
        rows[16] = '{32'h10c0, 32'h0,    32'h0,    0, 32'h0,    0, 0, 8};
        rows[17] = '{32'h10c0, 32'h0,    32'h0,    0, PC_A,     1, 1, 8};
        rows[18] = '{32'h10c0, PC_A,     32'h81c0, 1, 32'h0,    0, 0, 8};
        rows[19] = '{32'h10c0, 32'h0,    32'h0,    0, 32'h0,    1, 0, 8};
        rows[20] = '{32'h10c0, PC_ALIAS, 32'h8200, 1, 32'h0,    0, 0, 8};
        rows[21] = '{32'h10c0, PC_A,     32'h8240, 1, 32'h0,    0, 0, 8};
        rows[22] = '{32'h10c0, PC_B,     32'h9040, 1, 32'h0,    0, 0, 8};
        rows[23] = '{32'h10c0, PC_B,     32'h9020, 1, 32'h0,    0, 0, 8};
        rows[24] = '{32'h10c0, PC_B,     32'h9000, 1, 32'h0,    0, 0, 8};
        // access and anneal on one entry in the same cycle
        rows[25] = '{32'h10c0, PC_A,     32'h8280, 1, PC_A,     1, 1, 8};
    endtask

    task automatic apply_row(input stim_row_t r);
        @(posedge clk);
        pdc_pref_addr     <= r.fetch;
        dcache_pref_pc    <= r.pc;
        dcache_pref_addr  <= r.addr;
        dcache_pref_valid <= r.ld;
        anneal_pc         <= r.an_pc;
        anneal_addr       <= r.an_pc;
        anneal_unhit      <= r.an;
        anneal_type       <= r.an_type;
        @(posedge clk);
        dcache_pref_valid <= 1'b0;
        anneal_unhit      <= 1'b0;
        repeat (r.gap) @(posedge clk);
    endtask

    // cycle model that sees the same input values as the DUT at each edge
    always @(posedge clk) begin : ref_model
        logic [`PREF_LINE_WIDTH-1:0]  f_line;
        logic [`PREF_LINE_WIDTH-1:0]  l_line;
        logic [`PREF_LINE_WIDTH-1:0]  l_stride;
        logic [`PREF_INDEX_WIDTH-1:0] l_idx;
        logic [`PREF_INDEX_WIDTH-1:0] a_idx;
        logic [1:0]                   l_conf;
        logic                         l_hit;
        logic                         fb_now;
        if (!rstn) begin
            m_busy    = 1'b0;
            m_addr    = '0;
            m_kind    = 1'b0;
            m_inst_cv = 1'b0;
            m_data_cv = 1'b0;
            nl_valid  = 1'b0;
            for (int i = 0; i < ENTRIES; i++) begin
                ref_table[i].valid = 1'b0;
            end
        end else begin
            fb_now = 1'b0;
            if (m_busy) begin
                if (m_data_cv || m_inst_cv) begin
                    n_dropped++;
                end
                if (complete_l2cache_pref) begin
                    m_busy = 1'b0;
                    n_completed++;
                    if (hit_l2cache_pref) begin
                        n_hit++;
                    end
                    fb_now = hit_l2cache_pref && m_kind;
                end
            end else if (m_data_cv) begin
                m_busy = 1'b1;
                m_addr = {m_data_line, {`PREF_LINE_OFFSET{1'b0}}};
                m_kind = 1'b1;
                m_idx  = m_data_idx;
                n_issued++;
                n_data_req++;
                if (m_inst_cv) begin
                    n_dropped++;
                end
            end else if (m_inst_cv) begin
                m_busy = 1'b1;
                m_addr = {m_inst_line, {`PREF_LINE_OFFSET{1'b0}}};
                m_kind = 1'b0;
                n_issued++;
                n_inst_req++;
            end

            // next line
            f_line    = pdc_pref_addr[`PREF_ADDR_WIDTH-1:`PREF_LINE_OFFSET];
            m_inst_cv = 1'b0;
            if (anneal_unhit && !anneal_type) begin
                nl_valid = 1'b0;
            end else if (!nl_valid || f_line != nl_last) begin
                nl_valid    = 1'b1;
                nl_last     = f_line;
                m_inst_cv   = 1'b1;
                m_inst_line = f_line + 1;
            end

            // stride table
            l_idx    = dcache_pref_pc[TAG_LSB-1:2];
            a_idx    = anneal_pc[TAG_LSB-1:2];
            l_line   = dcache_pref_addr[`PREF_ADDR_WIDTH-1:`PREF_LINE_OFFSET];
            l_hit    = ref_table[l_idx].valid
                       && ref_table[l_idx].tag == dcache_pref_pc[`PREF_ADDR_WIDTH-1:TAG_LSB];
            l_stride = l_hit ? l_line - ref_table[l_idx].last_line : '0;
            l_conf   = 2'd0;
            if (l_hit && l_stride != '0 && l_stride == ref_table[l_idx].stride) begin
                l_conf = (ref_table[l_idx].conf == 2'(`PREF_CONF_MAX)) ?
                         ref_table[l_idx].conf : ref_table[l_idx].conf + 2'd1;
            end
            m_data_cv   = dcache_pref_valid && l_conf >= 2'(`PREF_CONF_THRESHOLD);
            m_data_line = l_line + l_stride;
            m_data_idx  = l_idx;
            // an access to the same entry wins over feedback and anneal
            if (fb_now && !(dcache_pref_valid && l_idx == m_idx)
                && ref_table[m_idx].conf != 2'd0) begin
                ref_table[m_idx].conf = ref_table[m_idx].conf - 2'd1;
            end
            if (anneal_unhit && anneal_type && !(dcache_pref_valid && l_idx == a_idx)) begin
                ref_table[a_idx].valid = 1'b0;
            end
            if (dcache_pref_valid) begin
                ref_table[l_idx] = '{1'b1, dcache_pref_pc[`PREF_ADDR_WIDTH-1:TAG_LSB],
                                     l_line, l_stride, l_conf};
            end
            if (anneal_unhit) begin
                n_anneal++;
            end
        end
    end

    // L2 responder with 1 to 4 cycles of delay and a random hit flag
    initial begin
        void'($urandom(32'h4fe5fa37));
        forever begin
            @(posedge clk);
            complete_l2cache_pref <= 1'b0;
            hit_l2cache_pref      <= 1'b0;
            if (!req_seen || complete_l2cache_pref) begin
                resp_wait = 0;
            end else if (resp_wait == 0) begin
                resp_wait = $urandom_range(4, 1);
            end else begin
                resp_wait = resp_wait - 1;
                if (resp_wait == 0) begin
                    complete_l2cache_pref <= 1'b1;
                    hit_l2cache_pref      <= $urandom_range(1, 0);
                end
            end
        end
    end

    always @(negedge clk) begin
        req_seen = req_pref_l2cache === 1'b1;
        if (checking) begin
            check_value("req_pref_l2cache", req_pref_l2cache, m_busy);
            check_value("addr_pref_l2cache", addr_pref_l2cache, m_addr);
            check_value("type_pref_l2cache", type_pref_l2cache, m_kind);
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        int n;
        rstn                  = 1'b0;
        pdc_pref_addr         = 32'h1000;
        dcache_pref_addr      = '0;
        dcache_pref_pc        = '0;
        dcache_pref_valid     = 1'b0;
        anneal_addr           = '0;
        anneal_pc             = '0;
        anneal_unhit          = 1'b0;
        anneal_type           = 1'b0;
        complete_l2cache_pref = 1'b0;
        hit_l2cache_pref      = 1'b0;
        fill_table();
        repeat (2) @(posedge clk);
        rstn     <= 1'b1;
        checking = 1'b1;
        @(negedge clk);
        check_value("stat_issued", stat_issued, 0);
        check_value("stat_dropped", stat_dropped, 0);
        check_value("stat_completed", stat_completed, 0);
        check_value("stat_hit", stat_hit, 0);
        check_value("stat_anneal", stat_anneal, 0);

        for (int i = 0; i < N_ROWS; i++) begin
            apply_row(rows[i]);
        end

        // let the last request close
        n = 0;
        @(negedge clk);
        while (req_pref_l2cache !== 1'b0 && n < DRAIN_CYCLES / 2) begin
            @(negedge clk);
            n++;
        end
        if (req_pref_l2cache !== 1'b0) begin
            err_count++;
            $display("request to the L2 still open after the stimulus ended");
        end
        repeat (4) @(negedge clk);
        check_value("stat_issued", stat_issued, n_issued);
        check_value("stat_dropped", stat_dropped, n_dropped);
        check_value("stat_completed", stat_completed, n_completed);
        check_value("stat_hit", stat_hit, n_hit);
        check_value("stat_anneal", stat_anneal, n_anneal);
        if (n_data_req == 0 || n_inst_req == 0 || n_dropped == 0) begin
            err_count++;
            $display("stimulus missed data requests, instruction requests or drops");
        end

        $display("checks: %0d, errors: %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
